/* rtl/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// lanes per cycle for dispatch, writeback and commit
`define ROB_DISPATCH_WIDTH  2

// two banks, slot k in bank k mod 2
`define ROB_BANK_ADDR_WIDTH 1
`define ROB_BANKS           2
`define ROB_ROWS            8
`define ROB_ADDR_WIDTH      3
`define ROB_ENTRIES         (`ROB_BANKS * `ROB_ROWS)
`define ROB_PTR_WIDTH       (`ROB_BANK_ADDR_WIDTH + `ROB_ADDR_WIDTH + 1)

// register files
`define ROB_PHYS_REGS       64
`define ROB_PHYS_ADDR_WIDTH 6
`define ROB_ARCH_ADDR_WIDTH 5

`endif

/* rtl/rob_pkg.sv */
`include "rob_consts.svh"

package rob_pkg;

  typedef logic [`ROB_PHYS_ADDR_WIDTH-1:0] phys_reg_t;
  typedef logic [`ROB_ARCH_ADDR_WIDTH-1:0] arch_reg_t;

  typedef logic [`ROB_BANK_ADDR_WIDTH-1:0] bank_addr_t;
  typedef logic [`ROB_ADDR_WIDTH-1:0]      rob_row_t;

  // slot index plus wrap bit on top
  typedef logic [`ROB_PTR_WIDTH-1:0]       rob_ptr_t;

  // 0 to 16 entries in flight
  typedef logic [`ROB_PTR_WIDTH-1:0]       rob_count_t;

  // one idle cycle after reset before dispatch opens
  typedef enum logic {
    RESET_INIT,
    RUN
  } ctrl_state_e;

endpackage

/* rtl/rob_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rob_consts.svh"

module rob_ctrl (
  input  wire                     clk,
  input  wire                     rst_n,

  input  wire                     dispatch_en        [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::bank_addr_t     dispatch_bank_addr [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::rob_row_t       dispatch_rob_addr  [0:`ROB_DISPATCH_WIDTH-1],
  output logic                    dispatch_full,
  output logic                    alloc_en           [0:`ROB_DISPATCH_WIDTH-1],

  output logic                    bank_wr_en         [0:`ROB_BANKS-1],
  output rob_pkg::rob_row_t       bank_wr_row        [0:`ROB_BANKS-1],
  output logic                    bank_wr_lane       [0:`ROB_BANKS-1],

  input  wire                     head_done          [0:`ROB_BANKS-1],
  input  wire rob_pkg::phys_reg_t head_phys          [0:`ROB_BANKS-1],
  input  wire rob_pkg::arch_reg_t head_arch          [0:`ROB_BANKS-1],
  output rob_pkg::rob_row_t       head_row           [0:`ROB_BANKS-1],
  output logic                    retire_en          [0:`ROB_BANKS-1],

  output logic                    commit_en          [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::phys_reg_t      commit_phys_rd     [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::arch_reg_t      commit_arch_rd     [0:`ROB_DISPATCH_WIDTH-1]
);

  import rob_pkg::*;

  ctrl_state_e state_q;
  rob_ptr_t    head_q;
  rob_ptr_t    tail_q;
  rob_count_t  count_q;

  rob_ptr_t    lane_slot   [0:`ROB_DISPATCH_WIDTH-1];
  rob_ptr_t    commit_slot [0:`ROB_DISPATCH_WIDTH-1];
  bank_addr_t  commit_bank [0:`ROB_DISPATCH_WIDTH-1];
  logic        entry_done  [0:`ROB_DISPATCH_WIDTH-1];
  rob_count_t  n_alloc;
  rob_count_t  n_commit;

  function automatic bank_addr_t slot_bank(input rob_ptr_t slot);
    return slot[`ROB_BANK_ADDR_WIDTH-1:0];
  endfunction

  function automatic rob_row_t slot_row(input rob_ptr_t slot);
    return slot[`ROB_BANK_ADDR_WIDTH +: `ROB_ADDR_WIDTH];
  endfunction

  // need room for a full two-wide group
  assign dispatch_full = (state_q == RESET_INIT) ||
                         (count_q > rob_count_t'(`ROB_ENTRIES - `ROB_DISPATCH_WIDTH));

  // dispatch lanes take consecutive slots from the tail
  always_comb begin
    lane_slot[0] = tail_q;
    for (int l = 1; l < `ROB_DISPATCH_WIDTH; l++) begin
      lane_slot[l] = lane_slot[l-1] + rob_ptr_t'(dispatch_en[l-1]);
    end
    n_alloc = '0;
    for (int b = 0; b < `ROB_BANKS; b++) begin
      bank_wr_en[b]   = 1'b0;
      bank_wr_row[b]  = '0;
      bank_wr_lane[b] = 1'b0;
    end
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      dispatch_bank_addr[l] = slot_bank(lane_slot[l]);
      dispatch_rob_addr[l]  = slot_row(lane_slot[l]);
      alloc_en[l]           = dispatch_en[l] && !dispatch_full;
      n_alloc               = n_alloc + rob_count_t'(alloc_en[l]);
      if (alloc_en[l]) begin
        bank_wr_en[slot_bank(lane_slot[l])]   = 1'b1;
        bank_wr_row[slot_bank(lane_slot[l])]  = slot_row(lane_slot[l]);
        bank_wr_lane[slot_bank(lane_slot[l])] = 1'(l);
      end
    end
  end

  // oldest entries sit in alternating banks from the head
  always_comb begin
    n_commit = '0;
    for (int b = 0; b < `ROB_BANKS; b++) begin
      head_row[b]  = '0;
      retire_en[b] = 1'b0;
    end
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      commit_slot[l] = head_q + rob_ptr_t'(l);
      commit_bank[l] = slot_bank(commit_slot[l]);
      head_row[commit_bank[l]] = slot_row(commit_slot[l]);
      entry_done[l]  = (count_q > rob_count_t'(l)) && head_done[commit_bank[l]];
    end
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      if (l == 0) begin
        commit_en[l] = entry_done[l];
      end else begin
        commit_en[l] = commit_en[l-1] && entry_done[l];
      end
      commit_phys_rd[l] = head_phys[commit_bank[l]];
      commit_arch_rd[l] = head_arch[commit_bank[l]];
      n_commit = n_commit + rob_count_t'(commit_en[l]);
      if (commit_en[l]) begin
        retire_en[commit_bank[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET_INIT;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      state_q <= RUN;
      head_q  <= head_q + rob_ptr_t'(n_commit);
      tail_q  <= tail_q + rob_ptr_t'(n_alloc);
      count_q <= count_q + n_alloc - n_commit;
    end
  end

endmodule

`default_nettype wire

/* rtl/rob_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rob_consts.svh"

module rob_bank #(
  parameter rob_pkg::bank_addr_t bank_id = '0
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // dispatch write, lane picked by the controller
  input  wire                     wr_en,
  input  wire rob_pkg::rob_row_t  wr_row,
  input  wire                     wr_lane,
  input  wire rob_pkg::phys_reg_t dispatch_phys_rd    [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::arch_reg_t dispatch_arch_rd    [0:`ROB_DISPATCH_WIDTH-1],

  input  wire rob_pkg::bank_addr_t writeback_bank_addr [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::rob_row_t  writeback_rob_addr  [0:`ROB_DISPATCH_WIDTH-1],
  input  wire                     writeback_en        [0:`ROB_DISPATCH_WIDTH-1],

  input  wire rob_pkg::rob_row_t  head_row,
  input  wire                     retire_en,
  output logic                    head_done,
  output rob_pkg::phys_reg_t      head_phys,
  output rob_pkg::arch_reg_t      head_arch,

  output logic                    ready_set_en        [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::phys_reg_t      ready_set_phys      [0:`ROB_DISPATCH_WIDTH-1]
);

  import rob_pkg::*;

  phys_reg_t            phys_q [0:`ROB_ROWS-1];
  arch_reg_t            arch_q [0:`ROB_ROWS-1];
  logic [`ROB_ROWS-1:0] done_q;
  logic [`ROB_ROWS-1:0] done_d;

  // writebacks addressed here, with the stored destination
  always_comb begin
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      ready_set_en[l]   = writeback_en[l] && (writeback_bank_addr[l] == bank_id);
      ready_set_phys[l] = phys_q[writeback_rob_addr[l]];
    end
  end

  assign head_done = done_q[head_row];
  assign head_phys = phys_q[head_row];
  assign head_arch = arch_q[head_row];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      phys_q[wr_row] <= dispatch_phys_rd[wr_lane];
      arch_q[wr_row] <= dispatch_arch_rd[wr_lane];
    end
  end

  // new entry starts not done
  always_comb begin
    done_d = done_q;
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      if (ready_set_en[l]) begin
        done_d[writeback_rob_addr[l]] = 1'b1;
      end
    end
    if (retire_en) begin
      done_d[head_row] = 1'b0;
    end
    if (wr_en) begin
      done_d[wr_row] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
    end else begin
      done_q <= done_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/phys_ready_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rob_consts.svh"

module phys_ready_table (
  input  wire                     clk,
  input  wire                     rst_n,

  input  wire                     alloc_en   [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::phys_reg_t alloc_phys [0:`ROB_DISPATCH_WIDTH-1],

  // one set port per bank and lane
  input  wire                     set_en     [0:`ROB_BANKS*`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::phys_reg_t set_phys   [0:`ROB_BANKS*`ROB_DISPATCH_WIDTH-1],

  input  wire rob_pkg::phys_reg_t rs1        [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::phys_reg_t rs2        [0:`ROB_DISPATCH_WIDTH-1],
  output logic                    rs1_valid  [0:`ROB_DISPATCH_WIDTH-1],
  output logic                    rs2_valid  [0:`ROB_DISPATCH_WIDTH-1]
);

  import rob_pkg::*;

  ctrl_state_e               state_q;
  logic [`ROB_PHYS_REGS-1:0] ready_q;
  logic [`ROB_PHYS_REGS-1:0] ready_d;

  // allocation applied last so the clear wins
  always_comb begin
    ready_d = ready_q;
    for (int i = 0; i < `ROB_BANKS * `ROB_DISPATCH_WIDTH; i++) begin
      if (set_en[i]) begin
        ready_d[set_phys[i]] = 1'b1;
      end
    end
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      if (alloc_en[l]) begin
        ready_d[alloc_phys[l]] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET_INIT;
      ready_q <= '1;
    end else begin
      state_q <= RUN;
      if (state_q == RUN) begin
        ready_q <= ready_d;
      end
    end
  end

  // nothing reads valid during init
  always_comb begin
    for (int l = 0; l < `ROB_DISPATCH_WIDTH; l++) begin
      rs1_valid[l] = (state_q == RUN) && ready_q[rs1[l]];
      rs2_valid[l] = (state_q == RUN) && ready_q[rs2[l]];
    end
  end

endmodule

`default_nettype wire

/* rtl/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "rob_consts.svh"

module rob_top (
  input  wire                      clk,
  input  wire                      rst_n,

  // dispatch
  input  wire rob_pkg::phys_reg_t  dispatch_phys_rd    [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::arch_reg_t  dispatch_arch_rd    [0:`ROB_DISPATCH_WIDTH-1],
  input  wire                      dispatch_en         [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::bank_addr_t      dispatch_bank_addr  [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::rob_row_t        dispatch_rob_addr   [0:`ROB_DISPATCH_WIDTH-1],
  output logic                     dispatch_full,

  // writeback
  input  wire rob_pkg::bank_addr_t writeback_bank_addr [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::rob_row_t   writeback_rob_addr  [0:`ROB_DISPATCH_WIDTH-1],
  input  wire                      writeback_en        [0:`ROB_DISPATCH_WIDTH-1],

  // commit
  output rob_pkg::phys_reg_t       commit_phys_rd      [0:`ROB_DISPATCH_WIDTH-1],
  output rob_pkg::arch_reg_t       commit_arch_rd      [0:`ROB_DISPATCH_WIDTH-1],
  output logic                     commit_en           [0:`ROB_DISPATCH_WIDTH-1],

  // operand fetch
  input  wire rob_pkg::phys_reg_t  op_fetch_phys_rs1   [0:`ROB_DISPATCH_WIDTH-1],
  input  wire rob_pkg::phys_reg_t  op_fetch_phys_rs2   [0:`ROB_DISPATCH_WIDTH-1],
  output logic                     op_fetch_rs1_valid  [0:`ROB_DISPATCH_WIDTH-1],
  output logic                     op_fetch_rs2_valid  [0:`ROB_DISPATCH_WIDTH-1]
);

  import rob_pkg::*;

  logic      alloc_en       [0:`ROB_DISPATCH_WIDTH-1];
  logic      bank_wr_en     [0:`ROB_BANKS-1];
  rob_row_t  bank_wr_row    [0:`ROB_BANKS-1];
  logic      bank_wr_lane   [0:`ROB_BANKS-1];
  logic      head_done      [0:`ROB_BANKS-1];
  phys_reg_t head_phys      [0:`ROB_BANKS-1];
  arch_reg_t head_arch      [0:`ROB_BANKS-1];
  rob_row_t  head_row       [0:`ROB_BANKS-1];
  logic      retire_en      [0:`ROB_BANKS-1];

  // bank 0 lanes first, then bank 1
  logic      ready_set_en   [0:`ROB_BANKS*`ROB_DISPATCH_WIDTH-1];
  phys_reg_t ready_set_phys [0:`ROB_BANKS*`ROB_DISPATCH_WIDTH-1];

  rob_ctrl i_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .dispatch_en        (dispatch_en),
    .dispatch_bank_addr (dispatch_bank_addr),
    .dispatch_rob_addr  (dispatch_rob_addr),
    .dispatch_full      (dispatch_full),
    .alloc_en           (alloc_en),
    .bank_wr_en         (bank_wr_en),
    .bank_wr_row        (bank_wr_row),
    .bank_wr_lane       (bank_wr_lane),
    .head_done          (head_done),
    .head_phys          (head_phys),
    .head_arch          (head_arch),
    .head_row           (head_row),
    .retire_en          (retire_en),
    .commit_en          (commit_en),
    .commit_phys_rd     (commit_phys_rd),
    .commit_arch_rd     (commit_arch_rd)
  );

  rob_bank #(.bank_id(1'b0)) i_bank0 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wr_en               (bank_wr_en[0]),
    .wr_row              (bank_wr_row[0]),
    .wr_lane             (bank_wr_lane[0]),
    .dispatch_phys_rd    (dispatch_phys_rd),
    .dispatch_arch_rd    (dispatch_arch_rd),
    .writeback_bank_addr (writeback_bank_addr),
    .writeback_rob_addr  (writeback_rob_addr),
    .writeback_en        (writeback_en),
    .head_row            (head_row[0]),
    .retire_en           (retire_en[0]),
    .head_done           (head_done[0]),
    .head_phys           (head_phys[0]),
    .head_arch           (head_arch[0]),
    .ready_set_en        (ready_set_en[0:1]),
    .ready_set_phys      (ready_set_phys[0:1])
  );

  rob_bank #(.bank_id(1'b1)) i_bank1 (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wr_en               (bank_wr_en[1]),
    .wr_row              (bank_wr_row[1]),
    .wr_lane             (bank_wr_lane[1]),
    .dispatch_phys_rd    (dispatch_phys_rd),
    .dispatch_arch_rd    (dispatch_arch_rd),
    .writeback_bank_addr (writeback_bank_addr),
    .writeback_rob_addr  (writeback_rob_addr),
    .writeback_en        (writeback_en),
    .head_row            (head_row[1]),
    .retire_en           (retire_en[1]),
    .head_done           (head_done[1]),
    .head_phys           (head_phys[1]),
    .head_arch           (head_arch[1]),
    .ready_set_en        (ready_set_en[2:3]),
    .ready_set_phys      (ready_set_phys[2:3])
  );

  phys_ready_table i_ready (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_en   (alloc_en),
    .alloc_phys (dispatch_phys_rd),
    .set_en     (ready_set_en),
    .set_phys   (ready_set_phys),
    .rs1        (op_fetch_phys_rs1),
    .rs2        (op_fetch_phys_rs2),
    .rs1_valid  (op_fetch_rs1_valid),
    .rs2_valid  (op_fetch_rs2_valid)
  );

endmodule

`default_nettype wire

/* dv/rob_tb.sv */
`timescale 1ns/1ps
`include "rob_consts.svh"

module rob_tb;

  import rob_pkg::*;

  localparam int LANES    = `ROB_DISPATCH_WIDTH;
  localparam int SLOTS    = `ROB_BANKS * `ROB_ROWS;
  localparam int MAX_ROWS = 96;

  logic       clk;
  logic       rst_n;
  phys_reg_t  dispatch_phys_rd    [0:LANES-1];
  arch_reg_t  dispatch_arch_rd    [0:LANES-1];
  logic       dispatch_en         [0:LANES-1];
  bank_addr_t dispatch_bank_addr  [0:LANES-1];
  rob_row_t   dispatch_rob_addr   [0:LANES-1];
  logic       dispatch_full;
  bank_addr_t writeback_bank_addr [0:LANES-1];
  rob_row_t   writeback_rob_addr  [0:LANES-1];
  logic       writeback_en        [0:LANES-1];
  phys_reg_t  commit_phys_rd      [0:LANES-1];
  arch_reg_t  commit_arch_rd      [0:LANES-1];
  logic       commit_en           [0:LANES-1];
  phys_reg_t  op_fetch_phys_rs1   [0:LANES-1];
  phys_reg_t  op_fetch_phys_rs2   [0:LANES-1];
  logic       op_fetch_rs1_valid  [0:LANES-1];
  logic       op_fetch_rs2_valid  [0:LANES-1];

  // stimulus columns, one row per cycle
  int               t_grp   [0:MAX_ROWS-1];
  logic [LANES-1:0] t_den   [0:MAX_ROWS-1];
  phys_reg_t        t_dphys [0:MAX_ROWS-1][0:LANES-1];
  arch_reg_t        t_darch [0:MAX_ROWS-1][0:LANES-1];
  logic [LANES-1:0] t_wen   [0:MAX_ROWS-1];
  int               t_wslot [0:MAX_ROWS-1][0:LANES-1];
  phys_reg_t        t_rs1   [0:MAX_ROWS-1][0:LANES-1];
  phys_reg_t        t_rs2   [0:MAX_ROWS-1][0:LANES-1];

  // expected columns
  logic             e_full  [0:MAX_ROWS-1];
  int               e_dslot [0:MAX_ROWS-1][0:LANES-1];
  logic [LANES-1:0] e_cen   [0:MAX_ROWS-1];
  phys_reg_t        e_cphys [0:MAX_ROWS-1][0:LANES-1];
  arch_reg_t        e_carch [0:MAX_ROWS-1][0:LANES-1];
  logic [LANES-1:0] e_v1    [0:MAX_ROWS-1];
  logic [LANES-1:0] e_v2    [0:MAX_ROWS-1];

  string grp_name [0:7];
  int    n_rows;
  int    n_grp;
  int    cur_grp;
  int    n_checks;
  int    n_err;
  int    grp_err;
  int    grp_rows;
  int    cycle_cnt;
  int    limit_cycles;

  rob_top i_dut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .dispatch_phys_rd    (dispatch_phys_rd),
    .dispatch_arch_rd    (dispatch_arch_rd),
    .dispatch_en         (dispatch_en),
    .dispatch_bank_addr  (dispatch_bank_addr),
    .dispatch_rob_addr   (dispatch_rob_addr),
    .dispatch_full       (dispatch_full),
    .writeback_bank_addr (writeback_bank_addr),
    .writeback_rob_addr  (writeback_rob_addr),
    .writeback_en        (writeback_en),
    .commit_phys_rd      (commit_phys_rd),
    .commit_arch_rd      (commit_arch_rd),
    .commit_en           (commit_en),
    .op_fetch_phys_rs1   (op_fetch_phys_rs1),
    .op_fetch_phys_rs2   (op_fetch_phys_rs2),
    .op_fetch_rs1_valid  (op_fetch_rs1_valid),
    .op_fetch_rs2_valid  (op_fetch_rs2_valid)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > limit_cycles) begin
        $display("simulation timed out after %0d cycles", cycle_cnt);
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      grp_err++;
      $display("FAIL t=%0t %s: got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic clear_row(input int r);
    t_den[r] = '0;
    t_wen[r] = '0;
    for (int l = 0; l < LANES; l++) begin
      t_dphys[r][l] = '0;
      t_darch[r][l] = '0;
      t_wslot[r][l] = 0;
      t_rs1[r][l]   = phys_reg_t'(l);
      t_rs2[r][l]   = phys_reg_t'(63 - l);
    end
  endtask

  task automatic start_group(input string name);
    grp_name[n_grp] = name;
    cur_grp = n_grp;
    n_grp++;
  endtask

  task automatic add_dispatch(input int l, input int phys, input int arch);
    t_den[n_rows][l]   = 1'b1;
    t_dphys[n_rows][l] = phys_reg_t'(phys);
    t_darch[n_rows][l] = arch_reg_t'(arch);
  endtask

  task automatic add_writeback(input int l, input int slot);
    t_wen[n_rows][l]   = 1'b1;
    t_wslot[n_rows][l] = slot;
  endtask

  task automatic add_fetch(input int l, input int rs1, input int rs2);
    t_rs1[n_rows][l] = phys_reg_t'(rs1);
    t_rs2[n_rows][l] = phys_reg_t'(rs2);
  endtask

  task automatic end_row();
    t_grp[n_rows] = cur_grp;
    n_rows++;
    clear_row(n_rows);
  endtask

  task automatic build_table();
    n_rows = 0;
    n_grp  = 0;
    clear_row(0);
    start_group("reset");
    end_row();
    add_fetch(0, 1, 2);
    add_fetch(1, 3, 63);
    end_row();
    // slots 0..3 with lanes 11, then lane 1 alone, then lane 0 alone
    start_group("alloc_order");
    add_dispatch(0, 10, 1);
    add_dispatch(1, 11, 2);
    end_row();
    add_dispatch(1, 12, 3);
    add_fetch(0, 10, 11);
    end_row();
    add_dispatch(0, 13, 4);
    add_fetch(0, 12, 11);
    end_row();
    start_group("ordering");
    add_writeback(0, 3);
    add_writeback(1, 2);
    end_row();
    add_writeback(0, 1);
    end_row();
    end_row();
    add_writeback(1, 0);
    end_row();
    end_row();
    end_row();
    end_row();
    // slots 4..18 fill the buffer to 15
    start_group("full");
    for (int i = 0; i < 7; i++) begin
      add_dispatch(0, 20 + 2 * i, 2 * i);
      add_dispatch(1, 21 + 2 * i, 2 * i + 1);
      end_row();
    end
    add_dispatch(0, 34, 14);
    end_row();
    add_dispatch(0, 50, 20);
    add_dispatch(1, 51, 21);
    add_fetch(0, 50, 51);
    end_row();
    add_dispatch(0, 50, 20);
    add_dispatch(1, 51, 21);
    add_writeback(0, 4);
    end_row();
    add_fetch(0, 50, 51);
    end_row();
    end_row();
    for (int s = 5; s < 19; s += 2) begin
      add_writeback(0, s);
      add_writeback(1, s + 1);
      end_row();
    end
    end_row();
    end_row();
    start_group("ready_bits");
    add_dispatch(0, 40, 7);
    add_fetch(0, 40, 41);
    end_row();
    add_fetch(0, 40, 41);
    add_fetch(1, 41, 40);
    end_row();
    add_writeback(0, 19);
    add_fetch(0, 40, 41);
    end_row();
    add_dispatch(0, 41, 8);
    add_fetch(0, 40, 41);
    end_row();
    // 41 written back and allocated again in one cycle
    add_writeback(0, 20);
    add_dispatch(1, 41, 9);
    add_fetch(0, 41, 40);
    end_row();
    add_fetch(0, 41, 40);
    end_row();
    add_writeback(1, 21);
    end_row();
    add_fetch(0, 41, 40);
    end_row();
    // slots 22..57 wrap the rows twice
    start_group("wraparound");
    for (int i = 0; i < 18; i++) begin
      add_dispatch(0, 44 + (2 * i) % 16, (2 * i) % 32);
      add_dispatch(1, 45 + (2 * i) % 16, (2 * i + 1) % 32);
      if (i > 0) begin
        add_writeback(0, 20 + 2 * i);
        add_writeback(1, 21 + 2 * i);
      end
      add_fetch(1, 44 + (2 * i) % 16, 45 + (2 * i) % 16);
      end_row();
    end
    add_writeback(0, 56);
    add_writeback(1, 57);
    end_row();
    end_row();
  endtask

  // expected values from the slot, full and commit rules, cycle by cycle
  task automatic predict_all();
    int                        head;
    int                        tail;
    int                        count;
    int                        slot;
    int                        n_acc;
    int                        n_com;
    logic                      init;
    logic                      done  [0:SLOTS-1];
    phys_reg_t                 phys  [0:SLOTS-1];
    arch_reg_t                 arch  [0:SLOTS-1];
    logic [`ROB_PHYS_REGS-1:0] ready;
    logic [`ROB_PHYS_REGS-1:0] set_bits;
    logic [`ROB_PHYS_REGS-1:0] clr_bits;
    head  = 0;
    tail  = 0;
    count = 0;
    init  = 1'b1;
    ready = '1;
    for (int s = 0; s < SLOTS; s++) begin
      done[s] = 1'b0;
      phys[s] = '0;
      arch[s] = '0;
    end
    for (int r = 0; r < n_rows; r++) begin
      e_full[r] = init || (count > SLOTS - LANES);
      slot = tail;
      for (int l = 0; l < LANES; l++) begin
        e_dslot[r][l] = slot % SLOTS;
        slot = slot + t_den[r][l];
      end
      for (int l = 0; l < LANES; l++) begin
        slot = (head + l) % SLOTS;
        e_cen[r][l]   = (count > l) && done[slot] && (l == 0 || e_cen[r][l-1]);
        e_cphys[r][l] = phys[slot];
        e_carch[r][l] = arch[slot];
        e_v1[r][l]    = !init && ready[t_rs1[r][l]];
        e_v2[r][l]    = !init && ready[t_rs2[r][l]];
      end
      set_bits = '0;
      clr_bits = '0;
      for (int l = 0; l < LANES; l++) begin
        if (t_wen[r][l]) begin
          slot = t_wslot[r][l] % SLOTS;
          done[slot] = 1'b1;
          set_bits[phys[slot]] = 1'b1;
        end
      end
      n_com = 0;
      for (int l = 0; l < LANES; l++) begin
        if (e_cen[r][l]) begin
          done[(head + l) % SLOTS] = 1'b0;
          n_com++;
        end
      end
      n_acc = 0;
      for (int l = 0; l < LANES; l++) begin
        if (!e_full[r] && t_den[r][l]) begin
          slot = (tail + n_acc) % SLOTS;
          phys[slot] = t_dphys[r][l];
          arch[slot] = t_darch[r][l];
          done[slot] = 1'b0;
          clr_bits[t_dphys[r][l]] = 1'b1;
          n_acc++;
        end
      end
      if (!init) begin
        ready = (ready | set_bits) & ~clr_bits;
      end
      head  = (head + n_com) % SLOTS;
      tail  = (tail + n_acc) % SLOTS;
      count = count + n_acc - n_com;
      init  = 1'b0;
    end
  endtask

  task automatic drive_row(input int r);
    for (int l = 0; l < LANES; l++) begin
      dispatch_en[l]         = t_den[r][l];
      dispatch_phys_rd[l]    = t_dphys[r][l];
      dispatch_arch_rd[l]    = t_darch[r][l];
      writeback_en[l]        = t_wen[r][l];
      writeback_bank_addr[l] = bank_addr_t'(t_wslot[r][l] % `ROB_BANKS);
      writeback_rob_addr[l]  = rob_row_t'((t_wslot[r][l] / `ROB_BANKS) % `ROB_ROWS);
      op_fetch_phys_rs1[l]   = t_rs1[r][l];
      op_fetch_phys_rs2[l]   = t_rs2[r][l];
    end
  endtask

  task automatic check_row(input int r);
    check_val(dispatch_full, e_full[r], $sformatf("row %0d dispatch_full", r));
    for (int l = 0; l < LANES; l++) begin
      check_val(dispatch_bank_addr[l], e_dslot[r][l] % `ROB_BANKS,
                $sformatf("row %0d lane %0d dispatch_bank_addr", r, l));
      check_val(dispatch_rob_addr[l], (e_dslot[r][l] / `ROB_BANKS) % `ROB_ROWS,
                $sformatf("row %0d lane %0d dispatch_rob_addr", r, l));
      check_val(commit_en[l], e_cen[r][l], $sformatf("row %0d lane %0d commit_en", r, l));
      if (e_cen[r][l]) begin
        check_val(commit_phys_rd[l], e_cphys[r][l],
                  $sformatf("row %0d lane %0d commit_phys_rd", r, l));
        check_val(commit_arch_rd[l], e_carch[r][l],
                  $sformatf("row %0d lane %0d commit_arch_rd", r, l));
      end
      check_val(op_fetch_rs1_valid[l], e_v1[r][l], $sformatf("row %0d lane %0d rs1_valid", r, l));
      check_val(op_fetch_rs2_valid[l], e_v2[r][l], $sformatf("row %0d lane %0d rs2_valid", r, l));
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    n_checks     = 0;
    n_err        = 0;
    grp_err      = 0;
    grp_rows     = 0;
    cycle_cnt    = 0;
    limit_cycles = MAX_ROWS;
    build_table();
    predict_all();
    limit_cycles = n_rows + 20;
    clear_row(MAX_ROWS - 1);
    drive_row(MAX_ROWS - 1);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      drive_row(r);
      @(negedge clk);
      check_row(r);
      grp_rows++;
      if (r == n_rows - 1 || t_grp[r+1] != t_grp[r]) begin
        $display("test %s: %0d rows, %0d mismatches", grp_name[t_grp[r]], grp_rows, grp_err);
        grp_rows = 0;
        grp_err  = 0;
      end
      @(posedge clk);
      #1;
    end
    $display("rows %0d, checks %0d, mismatches %0d", n_rows, n_checks, n_err);
    if (n_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_ctrl.sv
rtl/rob_bank.sv
rtl/phys_ready_table.sv
rtl/rob_top.sv
dv/rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rob_pkg.sv
      - rtl/rob_ctrl.sv
      - rtl/rob_bank.sv
      - rtl/phys_ready_table.sv
      - rtl/rob_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/rob_tb.sv
